//--- rtl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// core geometry
`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000

// major opcodes of the supported subset
`define RV_OP_R      7'b0110011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011

`endif

//--- rtl/rv_pkg.sv
package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_PC,
        SRC_A_OLD_PC,
        SRC_A_RS1
    } alu_src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR
    } alu_src_b_e;

    typedef enum logic [1:0] {
        RES_ALU,      // straight from the ALU
        RES_ALU_OUT,
        RES_MDR
    } res_src_e;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B
    } imm_src_e;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        MEM_W_RF,
        EXEC_R,
        ALU_W_RF,
        BRANCH
    } mcyc_state_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
    } rv_instr_u;

endpackage

//--- rtl/rv_ifaces.sv
`include "rv_defines.svh"

interface rv_ctrl_if;
    import rv_pkg::*;

    logic       rf_we;
    alu_src_a_e alu_src_a;
    alu_src_b_e alu_src_b;
    res_src_e   res_src;
    imm_src_e   imm_src;
    alu_op_e    alu_ctrl;
    logic       en_ir;
    logic       en_pc;
    logic       m_addr_src;   // 0 pc, 1 alu out
    logic       mem_start;
    logic       mem_we;
    rv_instr_u  instr;
    logic [3:0] alu_flags;    // neg, zero, carry, overflow

    modport ctrl (
        output rf_we, alu_src_a, alu_src_b, res_src, imm_src, alu_ctrl,
        output en_ir, en_pc, m_addr_src, mem_start, mem_we,
        input  instr, alu_flags
    );

    modport dp (
        input  rf_we, alu_src_a, alu_src_b, res_src, imm_src, alu_ctrl,
        input  en_ir, en_pc, m_addr_src,
        output instr, alu_flags
    );
endinterface

interface mem_req_if;
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] wdata;
    logic [`RV_XLEN-1:0] rdata;
    logic                start;
    logic                we;
    logic                done;

    modport requester_dp   (output addr, wdata, input rdata, done);
    modport requester_ctrl (output start, we, input done);
    modport master         (input addr, wdata, start, we, output rdata, done);
endinterface

//--- rtl/alu.sv
`include "rv_defines.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_e     op,
    output logic [`RV_XLEN-1:0] y,
    output logic [3:0]          flags
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN-1:0] sum;
    logic                sub;
    logic                cout;
    logic                ovf;
    logic                lt_s;

    assign sub   = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
    assign b_eff = sub ? ~b : b;
    assign {cout, sum} = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub};

    // signs agree going in, differ coming out
    assign ovf  = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) && (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);
    assign lt_s = sum[`RV_XLEN-1] ^ ovf;

    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB: y = sum;
            ALU_SLL:  y = a << b[4:0];
            ALU_SLT:  y = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, ~cout};   // no carry means a < b
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> b[4:0];
            ALU_SRA:  y = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = sum;
        endcase
    end

    assign flags = {y[`RV_XLEN-1], (y == '0), cout, ovf};
endmodule

//--- rtl/alu_dec.sv
`include "rv_defines.svh"

module alu_dec (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output rv_pkg::alu_op_e alu_op
);
    import rv_pkg::*;

    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == `RV_OP_R) begin
            case (funct3)
                3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (opcode == `RV_OP_BRANCH) begin
            alu_op = ALU_SUB;   // compare through flags
        end
    end
endmodule

//--- rtl/controller_multicycle.sv
`include "rv_defines.svh"

module controller_multicycle (
    input  logic              clk,
    input  logic              rst,
    rv_ctrl_if.ctrl           ctrl,
    mem_req_if.requester_ctrl mem
);
    import rv_pkg::*;

    mcyc_state_e state;
    mcyc_state_e decode_ns;
    alu_op_e     dec_op;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_load;
    logic        mem_state;
    logic        mem_busy;
    logic        taken;
    logic        f_neg;
    logic        f_zero;
    logic        f_carry;
    logic        f_ovf;

    assign opcode  = ctrl.instr.r.opcode;
    assign funct3  = ctrl.instr.r.funct3;
    assign is_load = (opcode == `RV_OP_LOAD);
    assign {f_neg, f_zero, f_carry, f_ovf} = ctrl.alu_flags;

    alu_dec u_alu_dec (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (ctrl.instr.r.funct7),
        .alu_op (dec_op)
    );

    always_comb begin
        case (opcode)
            `RV_OP_R:                  decode_ns = EXEC_R;
            `RV_OP_LOAD, `RV_OP_STORE: decode_ns = MEM_ADDR;
            `RV_OP_BRANCH:             decode_ns = BRANCH;
            default:                   decode_ns = FETCH;   // unknown opcode, skip it
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:     if (mem.done) state <= DECODE;
                DECODE:    state <= decode_ns;
                MEM_ADDR:  state <= is_load ? MEM_READ : MEM_WRITE;
                MEM_READ:  if (mem.done) state <= MEM_W_RF;
                MEM_WRITE: if (mem.done) state <= FETCH;
                EXEC_R:    state <= ALU_W_RF;
                default:   state <= FETCH;
            endcase
        end
    end

    // one start pulse per visit to a memory state
    assign mem_state = (state == FETCH) || (state == MEM_READ) || (state == MEM_WRITE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_busy <= 1'b0;
        end else begin
            mem_busy <= (mem_busy | ctrl.mem_start) & ~mem.done;
        end
    end

    assign ctrl.mem_start = mem_state & ~mem_busy;
    assign ctrl.mem_we    = (state == MEM_WRITE);
    assign mem.start      = ctrl.mem_start;
    assign mem.we         = ctrl.mem_we;

    always_comb begin
        case (funct3)
            3'b000:  taken = f_zero;               // beq
            3'b001:  taken = ~f_zero;              // bne
            3'b100:  taken = f_neg ^ f_ovf;        // blt
            3'b101:  taken = ~(f_neg ^ f_ovf);     // bge
            3'b110:  taken = ~f_carry;             // bltu
            3'b111:  taken = f_carry;              // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.rf_we      = 1'b0;
        ctrl.alu_src_a  = SRC_A_RS1;
        ctrl.alu_src_b  = SRC_B_IMM;
        ctrl.res_src    = RES_ALU_OUT;
        ctrl.imm_src    = is_load ? IMM_I : IMM_S;
        ctrl.alu_ctrl   = ALU_ADD;
        ctrl.en_ir      = 1'b0;
        ctrl.en_pc      = 1'b0;
        ctrl.m_addr_src = 1'b0;
        case (state)
            FETCH: begin
                ctrl.alu_src_a = SRC_A_PC;
                ctrl.alu_src_b = SRC_B_FOUR;
                ctrl.res_src   = RES_ALU;   // pc + 4
                ctrl.en_ir     = mem.done;
                ctrl.en_pc     = mem.done;
            end
            DECODE: begin
                ctrl.alu_src_a = SRC_A_OLD_PC;   // branch target into alu out
                ctrl.imm_src   = IMM_B;
            end
            MEM_READ, MEM_WRITE: begin
                ctrl.m_addr_src = 1'b1;
            end
            MEM_W_RF: begin
                ctrl.rf_we   = 1'b1;
                ctrl.res_src = RES_MDR;
            end
            EXEC_R: begin
                ctrl.alu_src_b = SRC_B_RS2;
                ctrl.alu_ctrl  = dec_op;
            end
            ALU_W_RF: begin
                ctrl.rf_we = 1'b1;
            end
            BRANCH: begin
                ctrl.alu_src_b = SRC_B_RS2;
                ctrl.alu_ctrl  = dec_op;
                ctrl.en_pc     = taken;   // target already in alu out
            end
            default: ;   // MEM_ADDR runs on the defaults
        endcase
    end
endmodule

//--- rtl/datapath.sv
`include "rv_defines.svh"

module datapath (
    input  logic            clk,
    input  logic            rst,
    rv_ctrl_if.dp           ctrl,
    mem_req_if.requester_dp mem
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] old_pc;
    rv_instr_u           ir;
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] a_reg;
    logic [`RV_XLEN-1:0] b_reg;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] mdr;
    logic [`RV_XLEN-1:0] imm_ext;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= `RV_RESET_PC;
            old_pc <= `RV_RESET_PC;
            ir     <= '0;
        end else begin
            if (ctrl.en_pc)
                pc <= result;
            if (ctrl.en_ir) begin
                old_pc <= pc;   // address of the fetched word
                ir     <= mem.rdata;
            end
        end
    end

    // x0 is cleared here and never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `RV_NREGS; r++)
                regs[r] <= '0;
        end else if (ctrl.rf_we && ir.r.rd != 5'd0) begin
            regs[ir.r.rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        a_reg   <= regs[ir.r.rs1];
        b_reg   <= regs[ir.r.rs2];
        alu_out <= alu_y;
        if (mem.done)
            mdr <= mem.rdata;
    end

    always_comb begin
        case (ctrl.imm_src)
            IMM_S:   imm_ext = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            IMM_B:   imm_ext = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11,
                                ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            default: imm_ext = {{20{ir.i.imm[11]}}, ir.i.imm};
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_a)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            default:      src_a = a_reg;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_b)
            SRC_B_RS2:  src_b = b_reg;
            SRC_B_FOUR: src_b = `RV_XLEN'd4;
            default:    src_b = imm_ext;
        endcase
    end

    alu u_alu (
        .a     (src_a),
        .b     (src_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_y),
        .flags (ctrl.alu_flags)
    );

    always_comb begin
        case (ctrl.res_src)
            RES_ALU: result = alu_y;
            RES_MDR: result = mdr;
            default: result = alu_out;
        endcase
    end

    assign ctrl.instr = ir;
    assign mem.addr   = ctrl.m_addr_src ? alu_out : pc;
    assign mem.wdata  = b_reg;
endmodule

//--- rtl/apb_master.sv
`include "rv_defines.svh"

module apb_master (
    input  logic                clk,
    input  logic                rst,
    mem_req_if.master           req,
    output logic [`RV_XLEN-1:0] paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`RV_XLEN-1:0] pwdata,
    input  logic [`RV_XLEN-1:0] prdata,
    input  logic                pready
);
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    apb_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pwrite   <= 1'b0;
            req.done <= 1'b0;
        end else begin
            req.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req.start) begin
                        state  <= SETUP;
                        pwrite <= req.we;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (pready) begin   // wait states hold here
                        state    <= IDLE;
                        req.done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req.start) begin
            paddr  <= req.addr;
            pwdata <= req.wdata;
        end
        if (state == ACCESS && pready)
            req.rdata <= prdata;
    end

    assign psel    = (state != IDLE);
    assign penable = (state == ACCESS);
endmodule

//--- rtl/rv_mcyc_core.sv
`include "rv_defines.svh"

module rv_mcyc_core (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`RV_XLEN-1:0] pwdata,
    input  logic [`RV_XLEN-1:0] prdata,
    input  logic                pready
);
    rv_ctrl_if ctrl_if ();
    mem_req_if mem_if ();

    controller_multicycle u_ctrl (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.ctrl),
        .mem  (mem_if.requester_ctrl)
    );

    datapath u_dp (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.dp),
        .mem  (mem_if.requester_dp)
    );

    // single shared port for fetch, load and store
    apb_master u_apb (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_if.master),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );
endmodule

//--- sim/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

//--- sim/tb_rv_mcyc.sv
module tb_rv_mcyc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MEM_WORDS   = 256;
    localparam int          TRACE_WORDS = 512;
    localparam int          EXP_BASE    = 256;   // word index of the store list
    localparam int          RST_LIMIT   = 100;
    localparam int          RUN_LIMIT   = 20000;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;

    logic        clk;
    logic        rst;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata = 32'h0;
    logic        pready = 1'b0;

    logic [31:0] trace_words [TRACE_WORDS];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int          seed         = 32'h7b4d_ac06;
    int          wait_left    = 0;
    int          store_idx    = 0;
    int          store_errors = 0;
    int          proto_errors = 0;
    int          other_errors = 0;
    logic        prev_setup   = 1'b0;
    logic        prev_wait    = 1'b0;
    logic        prev_read    = 1'b0;
    logic [31:0] prev_raddr   = 32'h0;
    logic        loop_seen    = 1'b0;
    logic        first_seen   = 1'b0;
    logic [31:0] held_addr    = 32'h0;
    logic        held_write   = 1'b0;
    logic [31:0] held_wdata   = 32'h0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rv_mcyc_core DUT (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    task automatic load_trace();
        int i;
        for (i = 0; i < TRACE_WORDS; i++)
            trace_words[i] = 32'hdead_0000 | i;   // unloaded words stay recognizable
        $readmemh("sim/rv_trace.txt", trace_words);
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = trace_words[i];
        i = EXP_BASE;
        while (i + 1 < TRACE_WORDS && trace_words[i] !== END_MARK) begin
            exp_addr.push_back(trace_words[i]);
            exp_data.push_back(trace_words[i + 1]);
            i += 2;
        end
        if (i + 1 >= TRACE_WORDS || exp_addr.size() == 0) begin
            $display("store list in the trace is empty or has no end marker");
            other_errors++;
        end
    endtask

    task automatic check_protocol();
        if (penable && !psel) begin
            $display("%0t: penable high while psel is low", $time);
            proto_errors++;
        end
        if (psel && penable && !(prev_setup || prev_wait)) begin
            $display("%0t: access phase without a setup cycle before it", $time);
            proto_errors++;
        end
        if (prev_setup && !(psel && penable)) begin
            $display("%0t: setup cycle not followed by an access phase", $time);
            proto_errors++;
        end
    endtask

    task automatic start_transfer();
        held_addr  = paddr;
        held_write = pwrite;
        held_wdata = pwdata;
        if (!first_seen) begin
            first_seen = 1'b1;
            if (paddr !== 32'h0) begin
                $display("[FAIL] t=%0t paddr: got %08h, expected 00000000", $time, paddr);
                proto_errors++;
            end
            if (pwrite !== 1'b0) begin
                $display("[FAIL] t=%0t pwrite: got %b, expected 0", $time, pwrite);
                proto_errors++;
            end
        end
        wait_left = $random(seed) & 3;   // 0 to 3 wait states
        pready <= (wait_left == 0);
        if (!pwrite) begin
            if (prev_read && paddr === prev_raddr)
                loop_seen = 1'b1;   // back-to-back reads of one word mean the final self-loop
            prev_raddr = paddr;
            if (paddr[31:10] != '0 || paddr[1:0] != 2'b00) begin
                $display("%0t: read from 0x%08h is outside the memory", $time, paddr);
                other_errors++;
                prdata <= 32'h0;
            end else begin
                prdata <= mem[paddr[9:2]];
            end
        end
        prev_read = !pwrite;
    endtask

    task automatic check_hold();
        if (paddr !== held_addr) begin
            $display("[FAIL] t=%0t paddr: got %08h, expected %08h", $time, paddr, held_addr);
            proto_errors++;
        end
        if (pwrite !== held_write) begin
            $display("[FAIL] t=%0t pwrite: got %b, expected %b", $time, pwrite, held_write);
            proto_errors++;
        end
        if (pwdata !== held_wdata) begin
            $display("[FAIL] t=%0t pwdata: got %08h, expected %08h", $time, pwdata, held_wdata);
            proto_errors++;
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (store_idx >= exp_addr.size()) begin
            $display("%0t: store of %08h to 0x%08h beyond the expected list", $time, data, addr);
            other_errors++;
        end else begin
            if (addr !== exp_addr[store_idx]) begin
                $display("[FAIL] t=%0t paddr: got %08h, expected %08h",
                         $time, addr, exp_addr[store_idx]);
                store_errors++;
            end
            if (data !== exp_data[store_idx]) begin
                $display("[FAIL] t=%0t pwdata: got %08h, expected %08h",
                         $time, data, exp_data[store_idx]);
                store_errors++;
            end
        end
        store_idx++;
        if (addr[31:10] == '0 && addr[1:0] == 2'b00)
            mem[addr[9:2]] = data;
    endtask

    // APB slave with random wait states
    always @(posedge clk) begin
        if (rst) begin
            pready     <= 1'b0;
            prev_setup = 1'b0;
            prev_wait  = 1'b0;
            if (psel !== 1'b0) begin
                $display("[FAIL] t=%0t psel: got %b, expected 0", $time, psel);
                proto_errors++;
            end
        end else begin
            check_protocol();
            if (psel && !penable) begin
                start_transfer();
            end else if (psel && penable) begin
                check_hold();
                if (pready) begin
                    pready <= 1'b0;   // transfer completes on this edge
                    if (pwrite)
                        check_store(paddr, pwdata);
                end else begin
                    wait_left = wait_left - 1;
                    pready <= (wait_left == 0);
                end
            end
            prev_setup = psel && !penable;
            prev_wait  = psel && penable && !pready;
        end
    end

    initial begin
        int cycles;
        load_trace();
        cycles = 0;
        while (rst && cycles < RST_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            $display("reset was never released");
            other_errors++;
        end
        cycles = 0;
        while (!loop_seen && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!loop_seen) begin
            $display("timeout: the core never reached its closing self-loop");
            other_errors++;
        end
        if (store_idx < exp_addr.size()) begin
            $display("only %0d of %0d expected stores were seen",
                     store_idx, exp_addr.size());
            other_errors++;
        end
        $display("errors: %0d store, %0d protocol, %0d other",
                 store_errors, proto_errors, other_errors);
        if (store_errors + proto_errors + other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end
endmodule

//--- sim/rv_trace.txt
// hex words, each block placed at the @ word address above it
// @000 program, @040 data words at byte 0x100, @100 expected stores as: address data
// the store list ends with the address ffffffff
@000
10002083 10402103 10802183 10C02203 // lw x1..x4 from 0x100..0x10c
11002283 11402303                   // lw x5, x6
002083B3 20702023 40208433 20802223 // add x7, sub x8, each stored
0020F4B3 20902423 0020E533 20A02623 // and x9, or x10
0020C5B3 20B02823 00609633 20C02A23 // xor x11, sll x12 by 0x24
0041D6B3 20D02C23 4041D733 20E02E23 // srl x13, sra x14
0041A7B3 22F02023 0041B833 23002223 // slt x15, sltu x16
4062D8B3 23102423 0050B933 23202623 // sra x17, sltu x18
403209B3 23302823 00208033 22002A23 // sub x19, write x0 then store it
00420463 28B02023 00320463 28A02023 // beq taken, then not taken
00321463 28B02223 00109463 28A02223 // bne
0042C463 28B02423 00324463 28A02423 // blt, taken case overflows
00325463 28B02623 0012D463 28A02623 // bge, not taken case overflows
00326463 28B02823 0041E463 28A02823 // bltu
0041F463 28B02A23 00327463 28A02A23 // bgeu
00000063                            // beq x0, x0, 0
@040
12345678 0F0F00FF FFFFFFF0 00000003
80000000 00000024
@100
00000200 21435777
00000204 03255579
00000208 02040078
0000020C 1F3F56FF
00000210 1D3B5687
00000214 23456780
00000218 1FFFFFFE
0000021C FFFFFFFE
00000220 00000001
00000224 00000000
00000228 F8000000
0000022C 00000001
00000230 00000013
00000234 00000000
00000280 1F3F56FF
00000284 1F3F56FF
00000288 1F3F56FF
0000028C 1F3F56FF
00000290 1F3F56FF
00000294 1F3F56FF
FFFFFFFF FFFFFFFF

//--- compile.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_ifaces.sv
rtl/alu.sv
rtl/alu_dec.sv
rtl/controller_multicycle.sv
rtl/datapath.sv
rtl/apb_master.sv
rtl/rv_mcyc_core.sv
sim/tb_clk_gen.sv
sim/tb_rv_mcyc.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_rv_mcyc
FILELIST  := compile.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)
TRACE     := sim/rv_trace.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
